/* sim.f */
source/mulOpPkg.sv
source/mulCtrlPkg.sv
source/reuseTracker.sv
source/mulSequencer.sv
source/shiftAddDatapath.sv
source/mulUnitTop.sv
verif/mulUnit_sva.sv
verif/mulUnitTb.sv

/* source/mulCtrlPkg.sv */
package mulCtrlPkg;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    STEP,
    FINISH
  } mulState_e;

  // sequencer to datapath command
  typedef struct packed {
    logic capture;
    logic step;
    // subtract instead of add on the sign bit of the multiplier
    logic lastStep;
  } dpCmd_t;

endpackage

/* source/mulOpPkg.sv */
package mulOpPkg;

  // multiply opcodes, unused codes fall back to MUL
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011
  } mulOp_e;

  // operand extension and result half, decoded from the opcode
  typedef struct packed {
    logic lUnsigned;
    logic rUnsigned;
    logic highHalf;
  } opFormat_t;

endpackage

/* source/mulSequencer.sv */
`timescale 1ns/1ns

module mulSequencer import mulCtrlPkg::*; #(
  parameter int parallelism = 32
) (
  input  logic   clk,
  input  logic   rstN,
  input  logic   start,
  input  logic   hit,
  output logic   accept,
  output logic   computed,
  output dpCmd_t cmd,
  output logic   busy,
  output logic   done
);

  localparam int cntWidth = $clog2(parallelism + 1);
  localparam logic [cntWidth-1:0] lastCount = cntWidth'(parallelism);

  mulState_e           state;
  mulState_e           nextState;
  logic [cntWidth-1:0] stepCnt;
  logic                finalStep;

  // requests are taken only from IDLE
  assign accept    = start && (state == IDLE);
  assign computed  = accept && !hit;
  assign finalStep = (state == STEP) && (stepCnt == lastCount);

  assign cmd.capture  = accept;
  assign cmd.step     = (state == STEP);
  assign cmd.lastStep = finalStep;

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (accept) begin
          nextState = hit ? FINISH : LOAD;
        end
      end
      LOAD: begin
        nextState = STEP;
      end
      STEP: begin
        if (finalStep) begin
          nextState = FINISH;
        end
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  // parallelism+1 steps, count 0 to parallelism
  always_ff @(posedge clk) begin
    if (!rstN) begin
      stepCnt <= '0;
    end else if (state == LOAD) begin
      stepCnt <= '0;
    end else if (state == STEP) begin
      stepCnt <= stepCnt + 1'b1;
    end
  end

  // busy only on the miss path, drops with the done pulse
  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= (state == FINISH);
      if (state == LOAD) begin
        busy <= 1'b1;
      end else if (state == FINISH) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

/* source/mulUnitTop.sv */
`timescale 1ns/1ns

module mulUnitTop import mulOpPkg::*, mulCtrlPkg::*; #(
  parameter int parallelism = 32
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   start,
  input  mulOp_e                 opCode,
  input  logic [parallelism-1:0] lOp,
  input  logic [parallelism-1:0] rOp,
  output logic [parallelism-1:0] result,
  output logic                   busy,
  output logic                   done
);

  logic   accept;
  logic   computed;
  logic   hit;
  dpCmd_t cmd;

  reuseTracker #(.parallelism(parallelism)) tracker (
    .clk      (clk),
    .rstN     (rstN),
    .opCode   (opCode),
    .lOp      (lOp),
    .rOp      (rOp),
    .accept   (accept),
    .computed (computed),
    .hit      (hit)
  );

  mulSequencer #(.parallelism(parallelism)) sequencer (
    .clk      (clk),
    .rstN     (rstN),
    .start    (start),
    .hit      (hit),
    .accept   (accept),
    .computed (computed),
    .cmd      (cmd),
    .busy     (busy),
    .done     (done)
  );

  shiftAddDatapath #(.parallelism(parallelism)) datapath (
    .clk    (clk),
    .rstN   (rstN),
    .cmd    (cmd),
    .opCode (opCode),
    .lOp    (lOp),
    .rOp    (rOp),
    .result (result)
  );

endmodule

/* source/reuseTracker.sv */
`timescale 1ns/1ns

module reuseTracker import mulOpPkg::*; #(
  parameter int parallelism = 32
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  mulOp_e                 opCode,
  input  logic [parallelism-1:0] lOp,
  input  logic [parallelism-1:0] rOp,
  input  logic                   accept,
  input  logic                   computed,
  output logic                   hit
);

  mulOp_e                 prevOpCode;
  logic [parallelism-1:0] prevLOp;
  logic [parallelism-1:0] prevROp;
  logic                   prevValid;

  logic lEqual;
  logic rEqual;
  logic opMatch;
  logic prevHigh;

  // nothing stored until the first computed request
  always_ff @(posedge clk) begin
    if (!rstN) begin
      prevValid <= 1'b0;
    end else if (computed) begin
      prevValid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (computed) begin
      prevOpCode <= opCode;
      prevLOp    <= lOp;
      prevROp    <= rOp;
    end
  end

  assign lEqual = (lOp == prevLOp);
  assign rEqual = (rOp == prevROp);

  // any high-half run also leaves the low half in the product registers
  assign prevHigh = (prevOpCode == MULH) || (prevOpCode == MULHSU) ||
                    (prevOpCode == MULHU);

  always_comb begin
    opMatch = 1'b0;
    if (opCode == prevOpCode) begin
      opMatch = 1'b1;
    end else if ((opCode == MUL) && prevHigh) begin
      opMatch = 1'b1;
    end
  end

  assign hit = accept && prevValid && lEqual && rEqual && opMatch;

endmodule

/* source/shiftAddDatapath.sv */
`timescale 1ns/1ns

module shiftAddDatapath import mulOpPkg::*, mulCtrlPkg::*; #(
  parameter int parallelism = 32
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  dpCmd_t                 cmd,
  input  mulOp_e                 opCode,
  input  logic [parallelism-1:0] lOp,
  input  logic [parallelism-1:0] rOp,
  output logic [parallelism-1:0] result
);

  opFormat_t curFmt;
  opFormat_t fmtQ;

  // operands extended to parallelism+1 bits
  logic [parallelism:0] lExt;
  logic [parallelism:0] rExt;
  logic [parallelism:0] mcandQ;
  logic [parallelism:0] mplierQ;

  // product pair, high accumulator and low multiplier/product bits
  logic [parallelism:0] prodHi;
  logic [parallelism:0] prodLo;
  logic                 firstStep;

  logic [parallelism:0]   curHi;
  logic [parallelism:0]   curLo;
  logic [parallelism+1:0] addend;
  logic [parallelism+1:0] sum;

  always_comb begin
    case (opCode)
      MULH: begin
        curFmt = '{lUnsigned: 1'b0, rUnsigned: 1'b0, highHalf: 1'b1};
      end
      MULHSU: begin
        curFmt = '{lUnsigned: 1'b1, rUnsigned: 1'b0, highHalf: 1'b1};
      end
      MULHU: begin
        curFmt = '{lUnsigned: 1'b1, rUnsigned: 1'b1, highHalf: 1'b1};
      end
      default: begin
        curFmt = '{lUnsigned: 1'b0, rUnsigned: 1'b0, highHalf: 1'b0};
      end
    endcase
  end

  assign lExt = curFmt.lUnsigned ? {1'b0, lOp} : {lOp[parallelism-1], lOp};
  assign rExt = curFmt.rUnsigned ? {1'b0, rOp} : {rOp[parallelism-1], rOp};

  // first step starts from a clear accumulator and the fresh multiplier,
  // so a capture on a hit leaves the product pair intact
  assign curHi = firstStep ? '0 : prodHi;
  assign curLo = firstStep ? mplierQ : prodLo;

  assign addend = curLo[0] ? {mcandQ[parallelism], mcandQ} : '0;

  always_comb begin
    if (cmd.lastStep) begin
      sum = {curHi[parallelism], curHi} - addend;
    end else begin
      sum = {curHi[parallelism], curHi} + addend;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      firstStep <= 1'b0;
    end else if (cmd.capture) begin
      firstStep <= 1'b1;
    end else if (cmd.step) begin
      firstStep <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.capture) begin
      fmtQ    <= curFmt;
      mcandQ  <= lExt;
      mplierQ <= rExt;
    end
  end

  // add then arithmetic shift right of the pair
  always_ff @(posedge clk) begin
    if (cmd.step) begin
      prodHi <= sum[parallelism+1:1];
      prodLo <= {sum[0], curLo[parallelism:1]};
    end
  end

  // high half sits one bit above the low half boundary
  always_comb begin
    if (fmtQ.highHalf) begin
      result = {prodHi[parallelism-2:0], prodLo[parallelism]};
    end else begin
      result = prodLo[parallelism-1:0];
    end
  end

endmodule

/* verif/mulStim.txt */
# opCode (0 MUL, 1 MULH, 2 MULHSU, 3 MULHU)  lOp  rOp  expected result  expected hit
# all values hex, one request per line
0 00000007 00000003 00000015 0
0 00000007 00000003 00000015 1
1 00000007 00000003 00000000 0
0 00000007 00000003 00000015 1
0 FFFFFFFF 00000002 FFFFFFFE 0
1 FFFFFFFF 00000002 FFFFFFFF 0
2 FFFFFFFF 00000002 00000001 0
3 FFFFFFFF 00000002 00000001 0
0 FFFFFFFF 00000002 FFFFFFFE 1
0 00000002 FFFFFFFF FFFFFFFE 0
1 00000002 FFFFFFFF FFFFFFFF 0
2 00000002 FFFFFFFF FFFFFFFF 0
3 00000002 FFFFFFFF 00000001 0
3 00000002 FFFFFFFF 00000001 1
0 80000000 80000000 00000000 0
1 80000000 80000000 40000000 0
2 80000000 80000000 C0000000 0
3 80000000 80000000 40000000 0
0 80000000 80000000 00000000 1
0 80000000 00000003 80000000 0
1 80000000 00000003 FFFFFFFE 0
2 80000000 00000003 00000001 0
3 80000000 00000003 00000001 0
0 FFFFFFFD FFFFFFF9 00000015 0
1 FFFFFFFD FFFFFFF9 00000000 0
2 FFFFFFFD FFFFFFF9 FFFFFFF9 0
3 FFFFFFFD FFFFFFF9 FFFFFFF6 0
3 FFFFFFFD FFFFFFF9 FFFFFFF6 1
0 FFFFFFFD FFFFFFF9 00000015 1
0 FFFFFFFD FFFFFFF8 00000018 0
0 12345678 FFFF0000 A9880000 0
1 12345678 FFFF0000 FFFFEDCB 0
2 12345678 FFFF0000 FFFFEDCB 0
3 12345678 FFFF0000 12344443 0
1 12345678 FFFF0000 FFFFEDCB 0
0 12345678 00010000 56780000 0
1 12345678 00010000 00001234 0
0 12345678 00010000 56780000 1

/* verif/mulUnitTb.sv */
`timescale 1ns/1ns

module mulUnitTb import mulOpPkg::*; ();

  localparam int parallelism = 32;
  localparam int waitLimit   = 100;
  localparam int missLatency = parallelism + 3;

  logic                   clk;
  logic                   rstN;
  logic                   start;
  mulOp_e                 opCode;
  logic [parallelism-1:0] lOp;
  logic [parallelism-1:0] rOp;
  logic [parallelism-1:0] result;
  logic                   busy;
  logic                   done;

  int errorCount;
  int passCount;
  int failCount;
  int reqCount;
  bit timedOut;

  mulUnitTop #(.parallelism(parallelism)) dut (
    .clk    (clk),
    .rstN   (rstN),
    .start  (start),
    .opCode (opCode),
    .lOp    (lOp),
    .rOp    (rOp),
    .result (result),
    .busy   (busy),
    .done   (done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic string opName(input mulOp_e op);
    case (op)
      MULH:    return "MULH";
      MULHSU:  return "MULHSU";
      MULHU:   return "MULHU";
      default: return "MUL";
    endcase
  endfunction

  // two clock cycles of reset, released on a falling edge
  task automatic applyReset();
    rstN  = 1'b0;
    start = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    assert (busy === 1'b0) else begin
      $display("CHECK FAILED: busy = %h after reset, expected %h", busy, 1'b0);
      errorCount++;
    end
    assert (done === 1'b0) else begin
      $display("CHECK FAILED: done = %h after reset, expected %h", done, 1'b0);
      errorCount++;
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic runRequest(input mulOp_e op, input logic [parallelism-1:0] l,
                            input logic [parallelism-1:0] r,
                            input logic [parallelism-1:0] expResult, input bit expHit);
    int   edges;
    int   expLatency;
    int   errorsBefore;
    logic expBusy;
    errorsBefore = errorCount;
    edges        = 0;
    expLatency   = expHit ? 1 : missLatency;
    start  = 1'b1;
    opCode = op;
    lOp    = l;
    rOp    = r;
    @(negedge clk);
    start = 1'b0;
    lOp   = ~l;
    rOp   = ~r;
    // busy rises one edge after start at the earliest
    assert (busy === 1'b0) else begin
      $display("CHECK FAILED: busy = %h after start of request %0d, expected %h", busy,
               reqCount, 1'b0);
      errorCount++;
    end
    while (!done && edges < waitLimit) begin
      @(negedge clk);
      edges++;
      start = 1'b0;
      // a miss keeps busy up until the edge where done rises
      expBusy = !expHit && (edges < missLatency);
      assert (busy === expBusy) else begin
        $display("CHECK FAILED: busy = %h in cycle %0d of request %0d, expected %h", busy,
                 edges, reqCount, expBusy);
        errorCount++;
      end
      // a start in the middle of a run must be dropped
      if (!expHit && edges == 10) begin
        start  = 1'b1;
        opCode = MULHU;
        lOp    = ~l;
        rOp    = r ^ 32'h1;
      end
    end
    start = 1'b0;
    if (!done) begin
      $display("request %0d: no done pulse within %0d cycles", reqCount, waitLimit);
      timedOut = 1'b1;
      errorCount++;
      failCount++;
      return;
    end
    assert (edges == expLatency) else begin
      $display("CHECK FAILED: done latency = %h, expected %h", edges, expLatency);
      errorCount++;
    end
    assert (result === expResult) else begin
      $display("CHECK FAILED: result = %h, expected %h", result, expResult);
      errorCount++;
    end
    @(negedge clk);
    assert (done === 1'b0) else begin
      $display("CHECK FAILED: done = %h one cycle after the pulse, expected %h", done, 1'b0);
      errorCount++;
    end
    if (errorCount == errorsBefore) begin
      passCount++;
    end else begin
      failCount++;
    end
    $display("request %0d: %s l=%h r=%h result=%h hit=%0d latency=%0d %s", reqCount,
             opName(op), l, r, result, expHit, edges,
             (errorCount == errorsBefore) ? "ok" : "FAILED");
  endtask

  initial begin
    int                     fd;
    int                     fields;
    string                  line;
    logic [31:0]            opVal;
    logic [31:0]            hitVal;
    logic [parallelism-1:0] lVal;
    logic [parallelism-1:0] rVal;
    logic [parallelism-1:0] resVal;
    mulOp_e                 lastOp;
    logic [parallelism-1:0] lastL;
    logic [parallelism-1:0] lastR;
    logic [parallelism-1:0] lastRes;
    rstN       = 1'b0;
    start      = 1'b0;
    opCode     = MUL;
    lOp        = '0;
    rOp        = '0;
    errorCount = 0;
    passCount  = 0;
    failCount  = 0;
    reqCount   = 0;
    timedOut   = 1'b0;
    lastOp     = MUL;
    lastL      = '0;
    lastR      = '0;
    lastRes    = '0;
    applyReset();
    fd = $fopen("verif/mulStim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file verif/mulStim.txt");
      errorCount++;
    end else begin
      while (!timedOut && !$feof(fd)) begin
        line   = "";
        fields = $fgets(line, fd);
        if (line.len() > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h", opVal, lVal, rVal, resVal, hitVal);
          if (fields == 5) begin
            reqCount++;
            lastOp  = mulOp_e'(opVal[2:0]);
            lastL   = lVal;
            lastR   = rVal;
            lastRes = resVal;
            runRequest(lastOp, lVal, rVal, resVal, hitVal[0]);
          end
        end
      end
      $fclose(fd);
    end
    if (reqCount == 0) begin
      $display("no requests were read from the stimulus file");
      errorCount++;
    end
    // reset forgets the stored request, so a repeat is a miss again
    if (!timedOut && reqCount > 0) begin
      applyReset();
      reqCount++;
      runRequest(lastOp, lastL, lastR, lastRes, 1'b0);
    end
    $display("%0d requests, %0d passed, %0d failed, %0d errors", reqCount, passCount,
             failCount, errorCount);
    if (timedOut || errorCount != 0 || failCount != 0) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  end

endmodule

/* verif/mulUnit_sva.sv */
`timescale 1ns/1ns

module mulUnitSva (
  input logic clk,
  input logic rstN,
  input logic busy,
  input logic done
);

  // done is a single-cycle pulse
  doneOneCycle: assert property (
    @(posedge clk) disable iff (!rstN) done |=> !done
  ) else $error("done held high for more than one cycle");

  // busy is already low when done rises
  doneNotBusy: assert property (
    @(posedge clk) disable iff (!rstN) $rose(done) |-> !busy
  ) else $error("busy still high while done rises");

  // busy only drops together with done
  busyFallsWithDone: assert property (
    @(posedge clk) disable iff (!rstN) $fell(busy) |-> $rose(done)
  ) else $error("busy fell without a done pulse");

  // sync reset clears both control outputs
  resetClears: assert property (
    @(posedge clk) !rstN |=> (!busy && !done)
  ) else $error("busy or done not cleared by reset");

endmodule

bind mulUnitTop mulUnitSva ctrlChecks (
  .clk  (clk),
  .rstN (rstN),
  .busy (busy),
  .done (done)
);
